// File: rtl/lcd_pkg.sv
package lcd_pkg;

  // panel command codes for the 8080 write bus
  // column address set, takes start and end column as two bytes each
  localparam logic [7:0] cmd_column_set   = 8'h2A;
  // page address set, same layout for rows
  localparam logic [7:0] cmd_page_set     = 8'h2B;
  // memory write, pixel data follows until csx goes high
  localparam logic [7:0] cmd_memory_write = 8'h2C;

  // what a word means to the splitter
  // command and param carry one byte, pixel carries two
  typedef enum logic [1:0] {
    kind_command = 2'd0,
    kind_param   = 2'd1,
    kind_pixel   = 2'd2
  } word_kind_t;

  // word handed from the sequencer to the splitter
  // a command or parameter sits in value[7:0]
  // a pixel uses all 16 bits, rgb565 style
  typedef struct packed {
    word_kind_t  kind;
    logic [15:0] value;
  } lcd_word_t;

  // one byte on the bus with its data/command select
  // dc low marks a command byte, dc high marks data
  typedef struct packed {
    logic       dc;
    logic [7:0] data;
  } lcd_byte_t;

endpackage

// File: rtl/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
  parameter int TICK_DIV    = 4,
  parameter int HEART_TICKS = 16
) (
  input  logic hwclk,
  input  logic reset,
  output logic tick,
  output logic heartbeat
);

  // counter widths, at least one bit even for a divide of one
  localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam int HW = (HEART_TICKS > 1) ? $clog2(HEART_TICKS) : 1;

  logic [CW-1:0] cyc_cnt;
  logic [HW-1:0] tick_cnt;

  // tick fires on the last cycle of each divide period
  assign tick = (cyc_cnt == CW'(TICK_DIV - 1));

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      cyc_cnt   <= '0;
      tick_cnt  <= '0;
      heartbeat <= 1'b0;
    end else begin
      // cycle counter wraps at the end of each period
      if (tick) begin
        cyc_cnt <= '0;
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
      // heartbeat flips once every HEART_TICKS ticks
      if (tick) begin
        if (tick_cnt == HW'(HEART_TICKS - 1)) begin
          tick_cnt  <= '0;
          heartbeat <= ~heartbeat;
        end else begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/fill_sequencer.sv
`timescale 1ns/1ps

module fill_sequencer #(
  parameter int WIN_W = 3,
  parameter int WIN_H = 2
) (
  input  logic              hwclk,
  input  logic              reset,
  input  logic [20:0]       pb,
  input  logic              splitter_busy,
  output logic              word_strobe,
  output lcd_pkg::lcd_word_t word,
  output logic              active
);

  import lcd_pkg::*;

  // last column and last page, sent as the window end address
  localparam logic [15:0] COL_END  = 16'(WIN_W - 1);
  localparam logic [15:0] PAGE_END = 16'(WIN_H - 1);
  // pixel count in 32 bits, wide enough for a 65535 square window
  localparam logic [31:0] PIX_TOTAL = 32'(WIN_W) * 32'(WIN_H);
  localparam logic [31:0] PIX_LAST  = PIX_TOTAL - 32'd1;

  typedef enum logic [2:0] {
    st_idle,
    st_col_cmd,
    st_col_param,
    st_page_cmd,
    st_page_param,
    st_mem_cmd,
    st_pixel
  } state_t;

  state_t      state;
  logic [16:0] pb_meta;
  logic [16:0] pb_sync;
  logic        start_prev;
  logic        press;
  logic [1:0]  param_idx;
  logic [31:0] pix_cnt;
  logic [15:0] colour;

  // parameter byte order is start hi, start lo, end hi, end lo
  // window always starts at zero
  function automatic logic [7:0] param_byte(input logic [15:0] last, input logic [1:0] idx);
    case (idx)
      2'd2:    param_byte = last[15:8];
      2'd3:    param_byte = last[7:0];
      default: param_byte = 8'h00;
    endcase
  endfunction

  // two flop synchroniser for the start button and the colour switches
  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      pb_meta    <= '0;
      pb_sync    <= '0;
      start_prev <= 1'b0;
    end else begin
      pb_meta    <= pb[16:0];
      pb_sync    <= pb_meta;
      start_prev <= pb_sync[0];
    end
  end

  // rising edge of the synchronised start button
  assign press = pb_sync[0] & ~start_prev;

  // hand a word over whenever the splitter is free
  assign active      = (state != st_idle);
  assign word_strobe = active && !splitter_busy;

  // word for the current step
  always_comb begin
    word = '{kind: kind_command, value: 16'h0000};
    case (state)
      st_col_cmd:    word = '{kind: kind_command, value: {8'h00, cmd_column_set}};
      st_col_param:  word = '{kind: kind_param, value: {8'h00, param_byte(COL_END, param_idx)}};
      st_page_cmd:   word = '{kind: kind_command, value: {8'h00, cmd_page_set}};
      st_page_param: word = '{kind: kind_param, value: {8'h00, param_byte(PAGE_END, param_idx)}};
      st_mem_cmd:    word = '{kind: kind_command, value: {8'h00, cmd_memory_write}};
      st_pixel:      word = '{kind: kind_pixel, value: colour};
      default:       word = '{kind: kind_command, value: 16'h0000};
    endcase
  end

  // colour is taken at the press and held for the whole fill
  always_ff @(posedge hwclk) begin
    if (state == st_idle && press) begin
      colour <= pb_sync[16:1];
    end
  end

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      param_idx <= 2'd0;
      pix_cnt   <= 32'd0;
    end else begin
      case (state)
        st_idle: begin
          // presses during a fill never reach this branch
          if (press) begin
            state <= st_col_cmd;
          end
        end
        st_col_cmd: begin
          if (word_strobe) begin
            state     <= st_col_param;
            param_idx <= 2'd0;
          end
        end
        st_col_param: begin
          if (word_strobe) begin
            param_idx <= param_idx + 2'd1;
            if (param_idx == 2'd3) begin
              state <= st_page_cmd;
            end
          end
        end
        st_page_cmd: begin
          if (word_strobe) begin
            state     <= st_page_param;
            param_idx <= 2'd0;
          end
        end
        st_page_param: begin
          if (word_strobe) begin
            param_idx <= param_idx + 2'd1;
            if (param_idx == 2'd3) begin
              state <= st_mem_cmd;
            end
          end
        end
        st_mem_cmd: begin
          if (word_strobe) begin
            state   <= st_pixel;
            pix_cnt <= 32'd0;
          end
        end
        st_pixel: begin
          // active drops once the last pixel word is handed over
          if (word_strobe) begin
            if (pix_cnt == PIX_LAST) begin
              state <= st_idle;
            end else begin
              pix_cnt <= pix_cnt + 32'd1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: rtl/pixel_splitter.sv
`timescale 1ns/1ps

module pixel_splitter (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               word_strobe,
  input  lcd_pkg::lcd_word_t word,
  input  logic               writer_busy,
  output logic               splitter_busy,
  output logic               byte_strobe,
  output lcd_pkg::lcd_byte_t bus_byte
);

  import lcd_pkg::*;

  lcd_word_t word_q;
  logic      held;
  // set once the high byte of a pixel has gone out
  logic      lo_pending;

  assign splitter_busy = held;
  // pass a byte on as soon as the writer is free
  assign byte_strobe   = held && !writer_busy;

  // byte for the current half of the held word
  always_comb begin
    case (word_q.kind)
      kind_command: bus_byte = '{dc: 1'b0, data: word_q.value[7:0]};
      kind_pixel: begin
        // high byte first
        if (lo_pending) begin
          bus_byte = '{dc: 1'b1, data: word_q.value[7:0]};
        end else begin
          bus_byte = '{dc: 1'b1, data: word_q.value[15:8]};
        end
      end
      default:      bus_byte = '{dc: 1'b1, data: word_q.value[7:0]};
    endcase
  end

  always_ff @(posedge hwclk) begin
    if (word_strobe) begin
      word_q <= word;
    end
  end

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      held       <= 1'b0;
      lo_pending <= 1'b0;
    end else begin
      if (word_strobe) begin
        held <= 1'b1;
      end
      if (byte_strobe) begin
        if (word_q.kind == kind_pixel && !lo_pending) begin
          lo_pending <= 1'b1;
        end else begin
          // word fully sent, free the slot
          held       <= 1'b0;
          lo_pending <= 1'b0;
        end
      end
    end
  end

  // sequencer must wait for the slot to clear
  word_while_busy: assert property (@(posedge hwclk) disable iff (reset)
    word_strobe |-> !splitter_busy);

endmodule

// File: rtl/bus_writer.sv
`timescale 1ns/1ps

module bus_writer (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               tick,
  input  logic               byte_strobe,
  input  lcd_pkg::lcd_byte_t bus_byte,
  output logic               writer_busy,
  output logic               byte_done,
  output logic               csx,
  output logic               wrx,
  output logic               dcx,
  output logic [7:0]         data
);

  import lcd_pkg::*;

  // empty, byte waiting for its first tick, wrx low waiting to rise
  typedef enum logic [1:0] {
    wr_empty,
    wr_loaded,
    wr_strobe
  } wr_state_t;

  wr_state_t state;
  lcd_byte_t byte_q;

  assign writer_busy = (state != wr_empty);

  always_ff @(posedge hwclk) begin
    if (byte_strobe) begin
      byte_q <= bus_byte;
    end
  end

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      state     <= wr_empty;
      csx       <= 1'b1;
      wrx       <= 1'b1;
      dcx       <= 1'b0;
      data      <= 8'h00;
      byte_done <= 1'b0;
    end else begin
      byte_done <= 1'b0;
      case (state)
        wr_empty: begin
          // no byte on this tick, release chip select
          if (tick) begin
            csx <= 1'b1;
          end
          if (byte_strobe) begin
            state <= wr_loaded;
          end
        end
        wr_loaded: begin
          // first tick puts the byte on the pins and pulls wrx low
          if (tick) begin
            dcx   <= byte_q.dc;
            data  <= byte_q.data;
            csx   <= 1'b0;
            wrx   <= 1'b0;
            state <= wr_strobe;
          end
        end
        wr_strobe: begin
          // panel latches on this rising edge of wrx
          if (tick) begin
            wrx       <= 1'b1;
            byte_done <= 1'b1;
            state     <= wr_empty;
          end
        end
        default: state <= wr_empty;
      endcase
    end
  end

  // write strobe only ever inside a chip select window
  wrx_needs_csx: assert property (@(posedge hwclk) disable iff (reset)
    !wrx |-> !csx);

  // splitter must hold its byte while the writer is full
  byte_while_busy: assert property (@(posedge hwclk) disable iff (reset)
    byte_strobe |-> !writer_busy);

endmodule

// File: rtl/status_display.sv
`timescale 1ns/1ps

module status_display (
  input  logic       hwclk,
  input  logic       reset,
  input  logic       byte_done,
  output logic [7:0] ss7,
  output logic [7:0] ss6,
  output logic [7:0] ss5,
  output logic [7:0] ss4,
  output logic [7:0] ss3,
  output logic [7:0] ss2,
  output logic [7:0] ss1,
  output logic [7:0] ss0
);

  // total bytes written to the panel since reset
  logic [31:0] byte_count;

  // hex digit to segments, gfedcba active high, dot off
  function automatic logic [7:0] hex_seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex_seg = 8'h3F;
      4'h1: hex_seg = 8'h06;
      4'h2: hex_seg = 8'h5B;
      4'h3: hex_seg = 8'h4F;
      4'h4: hex_seg = 8'h66;
      4'h5: hex_seg = 8'h6D;
      4'h6: hex_seg = 8'h7D;
      4'h7: hex_seg = 8'h07;
      4'h8: hex_seg = 8'h7F;
      4'h9: hex_seg = 8'h6F;
      4'hA: hex_seg = 8'h77;
      4'hB: hex_seg = 8'h7C;
      4'hC: hex_seg = 8'h39;
      4'hD: hex_seg = 8'h5E;
      4'hE: hex_seg = 8'h79;
      default: hex_seg = 8'h71;
    endcase
  endfunction

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      byte_count <= 32'd0;
    end else if (byte_done) begin
      byte_count <= byte_count + 32'd1;
    end
  end

  // ss7 is the most significant digit
  assign ss7 = hex_seg(byte_count[31:28]);
  assign ss6 = hex_seg(byte_count[27:24]);
  assign ss5 = hex_seg(byte_count[23:20]);
  assign ss4 = hex_seg(byte_count[19:16]);
  assign ss3 = hex_seg(byte_count[15:12]);
  assign ss2 = hex_seg(byte_count[11:8]);
  assign ss1 = hex_seg(byte_count[7:4]);
  assign ss0 = hex_seg(byte_count[3:0]);

endmodule

// File: rtl/board_top.sv
`timescale 1ns/1ps

module board_top #(
  parameter int TICK_DIV    = 4,
  parameter int HEART_TICKS = 16,
  parameter int WIN_W       = 3,
  parameter int WIN_H       = 2
) (
  input  logic        hwclk,
  input  logic        reset,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic [7:0]  ss7,
  output logic [7:0]  ss6,
  output logic [7:0]  ss5,
  output logic [7:0]  ss4,
  output logic [7:0]  ss3,
  output logic [7:0]  ss2,
  output logic [7:0]  ss1,
  output logic [7:0]  ss0,
  output logic        red,
  output logic        green,
  output logic        blue
);

  import lcd_pkg::*;

  logic      tick;
  logic      heartbeat;
  logic      word_strobe;
  lcd_word_t word;
  logic      active;
  logic      splitter_busy;
  logic      byte_strobe;
  lcd_byte_t bus_byte;
  logic      writer_busy;
  logic      byte_done;
  logic      csx;
  logic      wrx;
  logic      dcx;
  logic [7:0] data;

  // bus pacing and heartbeat
  tick_divider #(.TICK_DIV(TICK_DIV), .HEART_TICKS(HEART_TICKS)) tick_i (
    .hwclk(hwclk), .reset(reset), .tick(tick), .heartbeat(heartbeat));

  // start button, colour switches and the fill command stream
  fill_sequencer #(.WIN_W(WIN_W), .WIN_H(WIN_H)) seq_i (
    .hwclk(hwclk), .reset(reset), .pb(pb), .splitter_busy(splitter_busy),
    .word_strobe(word_strobe), .word(word), .active(active));

  pixel_splitter split_i (
    .hwclk(hwclk), .reset(reset), .word_strobe(word_strobe), .word(word),
    .writer_busy(writer_busy), .splitter_busy(splitter_busy),
    .byte_strobe(byte_strobe), .bus_byte(bus_byte));

  // 8080 write cycle onto the pins
  bus_writer writer_i (
    .hwclk(hwclk), .reset(reset), .tick(tick), .byte_strobe(byte_strobe),
    .bus_byte(bus_byte), .writer_busy(writer_busy), .byte_done(byte_done),
    .csx(csx), .wrx(wrx), .dcx(dcx), .data(data));

  status_display status_i (
    .hwclk(hwclk), .reset(reset), .byte_done(byte_done),
    .ss7(ss7), .ss6(ss6), .ss5(ss5), .ss4(ss4),
    .ss3(ss3), .ss2(ss2), .ss1(ss1), .ss0(ss0));

  // left[0] dcx, left[1] csx, left[2] rdx held high, left[4] wrx
  assign left  = {3'b000, wrx, 1'b0, 1'b1, csx, dcx};
  assign right = data;
  assign red   = heartbeat;
  assign green = active;
  assign blue  = 1'b0;

endmodule

// File: tb/board_top_tb.sv
`timescale 1ns/1ps

module board_top_tb;

  import lcd_pkg::*;

  localparam int TICK_DIV    = 4;
  localparam int HEART_TICKS = 16;
  localparam int WIN_W       = 3;
  localparam int WIN_H       = 2;
  // long enough for a whole fill of 23 bytes at 8 cycles each
  localparam int FILL_LIMIT  = 1000;

  // segment patterns gfedcba for hex digits 0 to F
  localparam logic [7:0] SEG_TABLE [16] = '{
    8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
    8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71
  };

  logic        hwclk;
  logic        reset;
  logic [20:0] pb;
  logic [7:0]  left;
  logic [7:0]  right;
  logic [7:0]  ss7;
  logic [7:0]  ss6;
  logic [7:0]  ss5;
  logic [7:0]  ss4;
  logic [7:0]  ss3;
  logic [7:0]  ss2;
  logic [7:0]  ss1;
  logic [7:0]  ss0;
  logic        red;
  logic        green;
  logic        blue;

  integer      seed = 90964;
  // bytes seen on the bus, and the bytes a fill should produce
  lcd_byte_t   seen_q[$];
  lcd_byte_t   exp_q[$];
  logic [31:0] expected_total;
  logic        wrx_prev;

  board_top #(
    .TICK_DIV(TICK_DIV), .HEART_TICKS(HEART_TICKS), .WIN_W(WIN_W), .WIN_H(WIN_H)
  ) dut_i (
    .hwclk(hwclk), .reset(reset), .pb(pb), .left(left), .right(right),
    .ss7(ss7), .ss6(ss6), .ss5(ss5), .ss4(ss4),
    .ss3(ss3), .ss2(ss2), .ss1(ss1), .ss0(ss0),
    .red(red), .green(green), .blue(blue));

  // 40 ns period
  initial hwclk = 1'b0;
  always #20 hwclk = ~hwclk;

  // bus monitor, a byte is latched where wrx rises with csx low
  // values read at the edge are the settled ones from the last cycle
  always @(posedge hwclk) begin
    if (reset) begin
      wrx_prev = 1'b1;
    end else begin
      if (left[4] && !wrx_prev && !left[1]) begin
        seen_q.push_back('{dc: left[0], data: right});
      end
      wrx_prev = left[4];
    end
  end

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_byte(input string name, input lcd_byte_t exp, input lcd_byte_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected dc=%0b data=%02h, actual dc=%0b data=%02h",
               name, exp.dc, exp.data, act.dc, act.data);
      stop_run();
    end
  endtask

  task automatic check_segments(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %02h, actual %02h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %0b, actual %0b", name, exp, act);
      stop_run();
    end
  endtask

  // all eight digits against the hex value of count, ss7 on top
  task automatic check_digits(input string name, input logic [31:0] count);
    logic [7:0] act [8];
    act[0] = ss0;
    act[1] = ss1;
    act[2] = ss2;
    act[3] = ss3;
    act[4] = ss4;
    act[5] = ss5;
    act[6] = ss6;
    act[7] = ss7;
    for (int i = 0; i < 8; i++) begin
      check_segments($sformatf("%s ss%0d", name, i), SEG_TABLE[count[4*i +: 4]], act[i]);
    end
  endtask

  function automatic logic [15:0] next_colour();
    integer r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // 8 cycles of reset, released on a rising edge
  task automatic reset_dut();
    @(posedge hwclk);
    reset <= 1'b1;
    pb    <= '0;
    repeat (8) @(posedge hwclk);
    seen_q.delete();
    expected_total = '0;
    reset <= 1'b0;
  endtask

  // colour and pb[0] go up together, pb[0] drops again after 4 cycles
  task automatic press_start(input logic [15:0] colour);
    @(posedge hwclk);
    pb[16:1] <= colour;
    pb[0]    <= 1'b1;
    repeat (4) @(posedge hwclk);
    pb[0]    <= 1'b0;
  endtask

  task automatic wait_green(input string name, input logic level, input int limit);
    int n;
    n = 0;
    while (green !== level) begin
      if (n >= limit) begin
        $display("%s: green did not go to %0b within %0d cycles", name, level, limit);
        stop_run();
      end
      @(negedge hwclk);
      n++;
    end
  endtask

  // csx high again means the bus has gone quiet
  task automatic wait_bus_idle(input string name, input int limit);
    int n;
    n = 0;
    while (left[1] !== 1'b1) begin
      if (n >= limit) begin
        $display("%s: csx stayed low for %0d cycles", name, limit);
        stop_run();
      end
      @(negedge hwclk);
      n++;
    end
  endtask

  task automatic wait_bytes(input string name, input int count, input int limit);
    int n;
    n = 0;
    while (seen_q.size() < count) begin
      if (n >= limit) begin
        $display("%s: only %0d of %0d bytes seen on the bus", name, seen_q.size(), count);
        stop_run();
      end
      @(negedge hwclk);
      n++;
    end
  endtask

  // column window, page window, memory write, then the pixels hi then lo
  task automatic fill_expected(input logic [15:0] colour);
    logic [15:0] col_end;
    logic [15:0] page_end;
    col_end  = 16'(WIN_W - 1);
    page_end = 16'(WIN_H - 1);
    exp_q.delete();
    exp_q.push_back('{dc: 1'b0, data: 8'h2A});
    exp_q.push_back('{dc: 1'b1, data: 8'h00});
    exp_q.push_back('{dc: 1'b1, data: 8'h00});
    exp_q.push_back('{dc: 1'b1, data: col_end[15:8]});
    exp_q.push_back('{dc: 1'b1, data: col_end[7:0]});
    exp_q.push_back('{dc: 1'b0, data: 8'h2B});
    exp_q.push_back('{dc: 1'b1, data: 8'h00});
    exp_q.push_back('{dc: 1'b1, data: 8'h00});
    exp_q.push_back('{dc: 1'b1, data: page_end[15:8]});
    exp_q.push_back('{dc: 1'b1, data: page_end[7:0]});
    exp_q.push_back('{dc: 1'b0, data: 8'h2C});
    for (int i = 0; i < WIN_W * WIN_H; i++) begin
      exp_q.push_back('{dc: 1'b1, data: colour[15:8]});
      exp_q.push_back('{dc: 1'b1, data: colour[7:0]});
    end
  endtask

  // drains the monitor queue against exp_q, nothing missing and nothing extra
  task automatic compare_fill(input string name);
    lcd_byte_t act;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (seen_q.size() == 0) begin
        $display("%s: bus carried %0d bytes, %0d expected", name, i, exp_q.size());
        stop_run();
      end
      act = seen_q.pop_front();
      check_byte($sformatf("%s byte %0d", name, i), exp_q[i], act);
    end
    if (seen_q.size() != 0) begin
      $display("%s: %0d extra bytes on the bus after the fill", name, seen_q.size());
      stop_run();
    end
    expected_total = expected_total + 32'(exp_q.size());
  endtask

  // press, wait for the whole fill to leave the bus, then check it
  task automatic run_fill(input string name, input logic [15:0] colour);
    press_start(colour);
    wait_green(name, 1'b1, 20);
    wait_green(name, 1'b0, FILL_LIMIT);
    wait_bus_idle(name, FILL_LIMIT);
    // one more full write cycle, bus and sequencer must stay quiet
    repeat (2 * TICK_DIV) @(negedge hwclk);
    fill_expected(colour);
    compare_fill(name);
    check_level({name, " csx"}, 1'b1, left[1]);
    check_level({name, " green"}, 1'b0, green);
    check_digits(name, expected_total);
  endtask

  task automatic test_reset_state();
    @(negedge hwclk);
    check_level("reset csx", 1'b1, left[1]);
    check_level("reset wrx", 1'b1, left[4]);
    check_level("reset rdx", 1'b1, left[2]);
    check_level("reset green", 1'b0, green);
    // unused pins sit at zero
    check_level("reset blue", 1'b0, blue);
    check_level("reset unused left", 1'b0, |{left[7:5], left[3]});
    check_digits("reset digits", 32'd0);
  endtask

  task automatic test_one_fill();
    run_fill("one fill", next_colour());
  endtask

  // switches change once the pixels are on the bus
  task automatic test_colour_held();
    logic [15:0] colour;
    colour = next_colour();
    press_start(colour);
    wait_green("colour held", 1'b1, 20);
    wait_bytes("colour held", 14, FILL_LIMIT);
    @(posedge hwclk);
    pb[16:1] <= ~colour;
    wait_green("colour held", 1'b0, FILL_LIMIT);
    wait_bus_idle("colour held", FILL_LIMIT);
    fill_expected(colour);
    compare_fill("colour held");
  endtask

  // a second press mid fill must not start another one
  task automatic test_press_ignored();
    logic [15:0] colour;
    colour = next_colour();
    press_start(colour);
    wait_green("press ignored", 1'b1, 20);
    wait_bytes("press ignored", 6, FILL_LIMIT);
    press_start(next_colour());
    check_level("press ignored busy", 1'b1, green);
    wait_green("press ignored", 1'b0, FILL_LIMIT);
    wait_bus_idle("press ignored", FILL_LIMIT);
    repeat (40) @(negedge hwclk);
    check_level("press ignored idle", 1'b0, green);
    fill_expected(colour);
    compare_fill("press ignored");
    check_digits("press ignored", expected_total);
  endtask

  // counter starts from a fresh reset so it holds exactly two fills
  task automatic test_byte_counter();
    reset_dut();
    run_fill("counter fill 1", next_colour());
    run_fill("counter fill 2", next_colour());
  endtask

  // first toggle lands 64 cycles after release, checked inside 60 to 68
  task automatic test_heartbeat();
    reset_dut();
    for (int n = 1; n <= 68; n++) begin
      @(negedge hwclk);
      if (n == 59) begin
        check_level("heartbeat early", 1'b0, red);
      end
    end
    check_level("heartbeat late", 1'b1, red);
  endtask

  initial begin
    reset          = 1'b1;
    pb             = '0;
    wrx_prev       = 1'b1;
    expected_total = '0;
    reset_dut();
    test_reset_state();
    test_one_fill();
    test_colour_held();
    test_press_ignored();
    test_byte_counter();
    test_heartbeat();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: sources.f
rtl/lcd_pkg.sv
rtl/tick_divider.sv
rtl/fill_sequencer.sv
rtl/pixel_splitter.sv
rtl/bus_writer.sv
rtl/status_display.sv
rtl/board_top.sv
tb/board_top_tb.sv

// File: run.sh
#!/bin/sh
# build and run the board_top testbench with Verilator
# exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module board_top_tb -f sources.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vboard_top_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
